//--- Bender.yml
package:
  name: clkrst

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/clkrst_pkg.sv
      - design/rst_request_gen.sv
      - design/rst_sync_bank.sv
      - design/rst_status_track.sv
      - design/clkrst_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/clkrst_props.sv
      - bench/clkrst_tb.sv

//--- bench/clkrst_props.sv
// reset distribution properties
// port level rules of clkrst_top bound in from the testbench

`timescale 1ns/1ps

module clkrst_props (
  input logic                  iCLK_SERDES_RXREC,
  input logic                  arst_n,
  input clkrst_pkg::chan_vec_t atx_pll_locked,
  input clkrst_pkg::chan_vec_t rst_rx_n,
  input clkrst_pkg::chan_vec_t rst_tx_n,
  input clkrst_pkg::chan_vec_t rx_ready_sticky,
  input logic                  ribbon_drive_low,
  input logic                  neighbor_drive_low
);

  int unsigned fail_count = 0;  // failed properties so far

  // sticky flag only while its rx side is out of reset
  sticky_in_reset: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!arst_n)
    (rx_ready_sticky & ~rst_rx_n) == '0)
  else
  begin
    $error("rx_ready_sticky high on a channel held in rx reset");
    fail_count++;
  end

  // unlocked pll keeps its tx domain in reset
  tx_without_lock: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!arst_n)
    (rst_tx_n & ~atx_pll_locked) == '0)
  else
  begin
    $error("rst_tx_n released on a channel without pll lock");
    fail_count++;
  end

  // a ribbon drive is always passed on to the neighbor
  ribbon_to_neighbor: assert property (@(posedge iCLK_SERDES_RXREC) disable iff (!arst_n)
    ribbon_drive_low |-> neighbor_drive_low)
  else
  begin
    $error("ribbon_drive_low without neighbor_drive_low");
    fail_count++;
  end

endmodule

//--- bench/clkrst_tb.sv
// reset distribution testbench
// drives clkrst_top through reset release, random control steps,
// async assertion, sticky rx ready and the timestamp / pad paths.
// the reference model below is checked at every falling edge where check_en is high

`timescale 1ns/1ps

`include "clkrst_consts.svh"

module clkrst_tb;

  localparam int          CLK_PERIOD  = 8;        // ns
  localparam int          N_STEPS     = 200;      // random steps
  localparam int          STEP_CYCLES = 6;        // cycles per step in the watchdog budget
  localparam int          TIMEOUT_NS  = N_STEPS * STEP_CYCLES * CLK_PERIOD + 2000;
  localparam int unsigned RNG_SEED    = 32'h1fbc;
  localparam int          STICKY_CH   = 3;        // odd channel of link 1

  logic                  iCLK_SERDES_RXREC;
  logic                  arst_n;
  logic                  chip_rst;
  clkrst_pkg::link_vec_t link_rst;
  clkrst_pkg::link_vec_t link_rx_rst;
  clkrst_pkg::link_vec_t link_tx_rst;
  clkrst_pkg::chan_vec_t atx_pll_locked;
  clkrst_pkg::chan_vec_t rx_ready;
  logic                  glb_ts_rst;
  logic                  sync_ribbon_n;
  logic                  sync_neighbor_n;
  clkrst_pkg::chan_vec_t rst_rx_n;
  clkrst_pkg::chan_vec_t rst_tx_n;
  clkrst_pkg::chan_vec_t rx_ready_sticky;
  logic                  rst_glb_timestamp;
  logic                  ribbon_drive_low;
  logic                  neighbor_drive_low;

  logic                  check_en;     // compare on the next falling edge
  string                 test_name;
  clkrst_pkg::chan_vec_t sticky_exp;   // kept by the stimulus
  logic [18:0]           expected;     // {rx, tx, ts, ribbon, neighbor}

  clkrst_top clkrst_top_inst (.*);

  bind clkrst_top clkrst_props props_inst (
    .iCLK_SERDES_RXREC  (iCLK_SERDES_RXREC),
    .arst_n             (arst_n),
    .atx_pll_locked     (atx_pll_locked),
    .rst_rx_n           (rst_rx_n),
    .rst_tx_n           (rst_tx_n),
    .rx_ready_sticky    (rx_ready_sticky),
    .ribbon_drive_low   (ribbon_drive_low),
    .neighbor_drive_low (neighbor_drive_low)
  );

  always #(CLK_PERIOD / 2) iCLK_SERDES_RXREC = ~iCLK_SERDES_RXREC;

  ////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////

  // settled outputs for the given input levels
  function automatic logic [18:0] expected_outputs(
    input logic                  chip,
    input clkrst_pkg::link_vec_t lnk,
    input clkrst_pkg::link_vec_t lrx,
    input clkrst_pkg::link_vec_t ltx,
    input clkrst_pkg::chan_vec_t pll,
    input logic                  glb,
    input logic                  rib_n,
    input logic                  nb_n
  );
    clkrst_pkg::chan_vec_t rx;
    clkrst_pkg::chan_vec_t tx;
    int                    l;
    for (int ch = 0; ch < `CLKRST_N_CHAN; ch++)
    begin
      l      = ch / `CLKRST_CHAN_PER_LINK;  // owning link
      rx[ch] = !chip && !lnk[l] && !lrx[l];
      tx[ch] = !chip && !lnk[l] && !ltx[l] && pll[ch];  // tx waits for lock
    end
    return {rx, tx, glb || !rib_n || !nb_n, glb, glb || !rib_n};
  endfunction

  task automatic check_equal(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  always @(negedge iCLK_SERDES_RXREC)
  begin
    if (check_en)
    begin
      expected = expected_outputs(chip_rst, link_rst, link_rx_rst, link_tx_rst,
                                  atx_pll_locked, glb_ts_rst, sync_ribbon_n,
                                  sync_neighbor_n);
      check_equal({test_name, " rst_rx_n"}, expected[18:11], rst_rx_n);
      check_equal({test_name, " rst_tx_n"}, expected[10:3], rst_tx_n);
      check_equal({test_name, " ts/ribbon/neighbor"}, expected[2:0],
                  {rst_glb_timestamp, ribbon_drive_low, neighbor_drive_low});
      check_equal({test_name, " rx_ready_sticky"}, sticky_exp, rx_ready_sticky);
    end
  end

  // bound port rules on clkrst_top
  always @(clkrst_top_inst.props_inst.fail_count)
  begin
    if (clkrst_top_inst.props_inst.fail_count != 0)
    begin
      $display("a bound property on the clkrst_top ports failed");
      $display("TB FAILED");
      $fatal(1, "property failure");
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers entered and left on a rising edge
  ////////////////////////////////////////////////////////////

  task automatic settle_and_compare(input string name, input int settle, input int hold);
    test_name = name;
    repeat (settle) @(posedge iCLK_SERDES_RXREC);
    check_en <= 1'b1;
    repeat (hold) @(posedge iCLK_SERDES_RXREC);
    check_en <= 1'b0;
  endtask

  task automatic random_step();
    chip_rst       <= ($urandom_range(7) == 0);  // chip reset now and then
    link_rst       <= clkrst_pkg::link_vec_t'($urandom & $urandom);
    link_rx_rst    <= clkrst_pkg::link_vec_t'($urandom & $urandom);
    link_tx_rst    <= clkrst_pkg::link_vec_t'($urandom & $urandom);
    atx_pll_locked <= clkrst_pkg::chan_vec_t'($urandom | $urandom);  // mostly locked
    glb_ts_rst     <= ($urandom_range(3) == 0);
    settle_and_compare("random_step", 2, 2);  // 4 cycles per step
  endtask

  task automatic pulse_rx_ready(input int ch);
    rx_ready[ch] <= 1'b1;
    @(posedge iCLK_SERDES_RXREC);
    rx_ready[ch] <= 1'b0;  // captured on this edge
    sticky_exp[ch] = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(RNG_SEED));
    iCLK_SERDES_RXREC = 1'b0;
    arst_n            = 1'b0;
    chip_rst          = 1'b0;
    link_rst          = '0;
    link_rx_rst       = '0;
    link_tx_rst       = '0;
    atx_pll_locked    = '1;
    rx_ready          = '0;
    glb_ts_rst        = 1'b0;
    sync_ribbon_n     = 1'b1;
    sync_neighbor_n   = 1'b1;
    check_en          = 1'b0;
    sticky_exp        = '0;
    test_name         = "init";

    repeat (3) @(posedge iCLK_SERDES_RXREC);
    arst_n <= 1'b1;
    settle_and_compare("reset_release", 4, 1);

    for (int s = 0; s < N_STEPS; s++)
      random_step();

    // back to all clear
    chip_rst       <= 1'b0;
    link_rst       <= '0;
    link_rx_rst    <= '0;
    link_tx_rst    <= '0;
    atx_pll_locked <= '1;
    glb_ts_rst     <= 1'b0;
    settle_and_compare("all_clear", 2, 1);

    // link 2 down without waiting for a clock
    link_rst[2] <= 1'b1;
    settle_and_compare("async_link_rst", 0, 1);
    link_rst[2] <= 1'b0;
    settle_and_compare("link_rst_release", 2, 1);

    // sticky flag survives rx_ready dropping
    pulse_rx_ready(STICKY_CH);
    settle_and_compare("sticky_hold", 3, 1);
    link_rx_rst[STICKY_CH / `CLKRST_CHAN_PER_LINK] <= 1'b1;
    sticky_exp = '0;
    settle_and_compare("sticky_clear", 0, 1);
    link_rx_rst[STICKY_CH / `CLKRST_CHAN_PER_LINK] <= 1'b0;
    settle_and_compare("sticky_stays_clear", 4, 1);
    pulse_rx_ready(STICKY_CH);
    settle_and_compare("sticky_set_again", 0, 1);

    // timestamp sources
    glb_ts_rst <= 1'b1;
    settle_and_compare("ts_local", 2, 1);
    glb_ts_rst    <= 1'b0;
    sync_ribbon_n <= 1'b0;
    settle_and_compare("ts_ribbon", 2, 1);
    sync_ribbon_n   <= 1'b1;
    sync_neighbor_n <= 1'b0;
    settle_and_compare("ts_neighbor", 3, 1);
    sync_neighbor_n <= 1'b1;
    settle_and_compare("pads_idle", 4, 1);

    // let the property checks of the last edge finish
    @(negedge iCLK_SERDES_RXREC);
    $display("TB PASSED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- design/clkrst_consts.svh
// clock/reset distribution constants
// sizes for the link and channel vectors and the reset synchronizer depth
// shared by the package and the RTL blocks

`ifndef CLKRST_CONSTS_SVH
`define CLKRST_CONSTS_SVH

////////////////////////////////////////////////////////////
// link / channel geometry
////////////////////////////////////////////////////////////

`define CLKRST_N_LINKS       4   // fc links on this front end
`define CLKRST_CHAN_PER_LINK 2   // serdes channels per link, even + odd

// total serdes channels
`define CLKRST_N_CHAN        (`CLKRST_N_LINKS * `CLKRST_CHAN_PER_LINK)

////////////////////////////////////////////////////////////
// synchronizer
////////////////////////////////////////////////////////////

// flops per reset chain, sets release latency in cycles
`define CLKRST_SYNC_STAGES   2

`endif

//--- design/clkrst_pkg.sv
// clock/reset distribution types
// per-link and per-channel vectors plus the two payloads that travel
// through the reset synchronizer banks

`include "clkrst_consts.svh"

package clkrst_pkg;

  ////////////////////////////////////////////////////////////
  // vectors
  ////////////////////////////////////////////////////////////

  // one bit per link
  typedef logic [`CLKRST_N_LINKS-1:0] link_vec_t;

  // one bit per channel, even chan = 2*link, odd chan = 2*link+1
  typedef logic [`CLKRST_N_CHAN-1:0] chan_vec_t;

  ////////////////////////////////////////////////////////////
  // synchronizer payloads
  ////////////////////////////////////////////////////////////

  // active low per-channel resets, rx and tx side
  typedef struct packed {
    chan_vec_t rx_n;   // rx recovered clock domain
    chan_vec_t tx_n;   // tx domain, also waits for atx pll lock
  } chan_rst_t;

  // active low sync pad levels
  typedef struct packed {
    logic ribbon_n;    // shared ribbon line
    logic neighbor_n;  // line to the neighbor board
  } pad_sync_t;

endpackage

//--- design/clkrst_top.sv
// fc serdes front end reset distribution, top level
// request generator -> reset synchronizers -> rx status / timestamp logic
// everything runs on the recovered rx clock with the chip async reset
// sync pads come in as sampled levels and leave as drive-low enables

`timescale 1ns/1ps

module clkrst_top (
  input  logic                  iCLK_SERDES_RXREC,
  input  logic                  arst_n,
  // reset control levels
  input  logic                  chip_rst,
  input  clkrst_pkg::link_vec_t link_rst,
  input  clkrst_pkg::link_vec_t link_rx_rst,
  input  clkrst_pkg::link_vec_t link_tx_rst,
  // from serdes
  input  clkrst_pkg::chan_vec_t atx_pll_locked,
  input  clkrst_pkg::chan_vec_t rx_ready,
  // timestamp reset, local and from the pads
  input  logic                  glb_ts_rst,
  input  logic                  sync_ribbon_n,
  input  logic                  sync_neighbor_n,
  // per channel resets, active low
  output clkrst_pkg::chan_vec_t rst_rx_n,
  output clkrst_pkg::chan_vec_t rst_tx_n,
  // status and pad control
  output clkrst_pkg::chan_vec_t rx_ready_sticky,
  output logic                  rst_glb_timestamp,
  output logic                  ribbon_drive_low,
  output logic                  neighbor_drive_low
);

  clkrst_pkg::chan_rst_t req;       // raw requests, combinational
  clkrst_pkg::chan_rst_t chan_rst;  // synchronized channel resets
  clkrst_pkg::pad_sync_t pad_raw;   // pad levels as sampled
  clkrst_pkg::pad_sync_t pad_sync;  // pad levels on our clock

  ////////////////////////////////////////////////////////////
  // reset requests
  ////////////////////////////////////////////////////////////

  rst_request_gen request_gen_inst (
    .chip_rst       (chip_rst),
    .link_rst       (link_rst),
    .link_rx_rst    (link_rx_rst),
    .link_tx_rst    (link_tx_rst),
    .atx_pll_locked (atx_pll_locked),
    .req            (req)
  );

  ////////////////////////////////////////////////////////////
  // synchronizers
  ////////////////////////////////////////////////////////////

  rst_sync_bank #(
    .payload_t (clkrst_pkg::chan_rst_t)
  ) chan_sync_inst (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .arst_n            (arst_n),
    .async_in          (req),
    .sync_out          (chan_rst)
  );

  assign rst_rx_n = chan_rst.rx_n;
  assign rst_tx_n = chan_rst.tx_n;

  assign pad_raw.ribbon_n   = sync_ribbon_n;
  assign pad_raw.neighbor_n = sync_neighbor_n;

  // pads treated as resets, low asserts at once
  rst_sync_bank #(
    .payload_t (clkrst_pkg::pad_sync_t)
  ) pad_sync_inst (
    .iCLK_SERDES_RXREC (iCLK_SERDES_RXREC),
    .arst_n            (arst_n),
    .async_in          (pad_raw),
    .sync_out          (pad_sync)
  );

  ////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////

  rst_status_track status_track_inst (
    .iCLK_SERDES_RXREC  (iCLK_SERDES_RXREC),
    .arst_n             (arst_n),
    .rst_rx_n           (chan_rst.rx_n),
    .rx_ready           (rx_ready),
    .pad_sync           (pad_sync),
    .glb_ts_rst         (glb_ts_rst),
    .rx_ready_sticky    (rx_ready_sticky),
    .rst_glb_timestamp  (rst_glb_timestamp),
    .ribbon_drive_low   (ribbon_drive_low),
    .neighbor_drive_low (neighbor_drive_low)
  );

endmodule

//--- design/rst_request_gen.sv
// per-channel reset request generator
// merges chip reset, per-link reset and the per-link rx/tx reset levels,
// fans each link out to its two serdes channels and holds the tx side
// in reset until that channel's atx pll reports lock
// pure combinational, request bit low = reset wanted

`timescale 1ns/1ps

`include "clkrst_consts.svh"

module rst_request_gen (
  input  logic                  chip_rst,        // whole front end
  input  clkrst_pkg::link_vec_t link_rst,        // full link, rx and tx
  input  clkrst_pkg::link_vec_t link_rx_rst,     // rx side only
  input  clkrst_pkg::link_vec_t link_tx_rst,     // tx side only
  input  clkrst_pkg::chan_vec_t atx_pll_locked,  // per channel tx pll
  output clkrst_pkg::chan_rst_t req              // active low requests
);

  clkrst_pkg::link_vec_t link_up;  // link clear of chip and link reset
  clkrst_pkg::link_vec_t rx_up;    // rx side may run
  clkrst_pkg::link_vec_t tx_up;    // tx side may run, before pll lock

  ////////////////////////////////////////////////////////////
  // per-link release terms
  ////////////////////////////////////////////////////////////

  // chip reset knocks out every link
  assign link_up = ~link_rst & {`CLKRST_N_LINKS{~chip_rst}};

  assign rx_up = link_up & ~link_rx_rst;
  assign tx_up = link_up & ~link_tx_rst;

  ////////////////////////////////////////////////////////////
  // spread links to channels
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    req = '0;  // every bit overwritten below
    for (int l = 0; l < `CLKRST_N_LINKS; l++)
    begin
      for (int k = 0; k < `CLKRST_CHAN_PER_LINK; k++)
      begin
        // rx follows the link controls only
        req.rx_n[l*`CLKRST_CHAN_PER_LINK + k] = rx_up[l];
        // tx also needs its own pll locked
        req.tx_n[l*`CLKRST_CHAN_PER_LINK + k] =
          tx_up[l] & atx_pll_locked[l*`CLKRST_CHAN_PER_LINK + k];
      end
    end
  end

endmodule

//--- design/rst_status_track.sv
// reset status tracking
// sticky rx_ready per channel, cleared only by that channel's rx reset,
// so a flapping cdr lock does not bounce the link.
// also registers the global timestamp reset and forms the drive-low
// enables for the open-drain ribbon and neighbor sync pads

`timescale 1ns/1ps

`include "clkrst_consts.svh"

module rst_status_track (
  input  logic                  iCLK_SERDES_RXREC,
  input  logic                  arst_n,
  input  clkrst_pkg::chan_vec_t rst_rx_n,         // synchronized rx resets
  input  clkrst_pkg::chan_vec_t rx_ready,         // raw cdr ready, may flap
  input  clkrst_pkg::pad_sync_t pad_sync,         // synchronized pad levels
  input  logic                  glb_ts_rst,       // local timestamp reset
  output clkrst_pkg::chan_vec_t rx_ready_sticky,
  output logic                  rst_glb_timestamp,
  output logic                  ribbon_drive_low,
  output logic                  neighbor_drive_low
);

  wire  [`CLKRST_N_CHAN-1:0] sticky_bits;  // gathered from g_sticky
  logic                      ts_cond;      // any timestamp reset source

  ////////////////////////////////////////////////////////////
  // sticky rx ready
  ////////////////////////////////////////////////////////////

  for (genvar c = 0; c < `CLKRST_N_CHAN; c++)
  begin : g_sticky
    logic clr_n;  // channel rx reset or chip reset
    logic flag;

    assign clr_n = rst_rx_n[c] & arst_n;

    always_ff @(posedge iCLK_SERDES_RXREC or negedge clr_n)
    begin
      if (!clr_n)
        flag <= 1'b0;
      else if (rx_ready[c])
        flag <= 1'b1;  // first ready wins, holds from here
    end

    assign sticky_bits[c] = flag;
  end

  assign rx_ready_sticky = sticky_bits;

  ////////////////////////////////////////////////////////////
  // global timestamp reset and pad enables
  ////////////////////////////////////////////////////////////

  // local request, or another board pulling either pad low
  assign ts_cond = glb_ts_rst | ~pad_sync.ribbon_n | ~pad_sync.neighbor_n;

  always_ff @(posedge iCLK_SERDES_RXREC or negedge arst_n)
  begin
    if (!arst_n)
      rst_glb_timestamp <= 1'b0;
    else
      rst_glb_timestamp <= ts_cond;
  end

  assign ribbon_drive_low   = glb_ts_rst;  // ribbon only on own request
  // pass a ribbon reset on down the neighbor chain
  assign neighbor_drive_low = glb_ts_rst | ~pad_sync.ribbon_n;

endmodule

//--- design/rst_sync_bank.sv
// reset synchronizer bank
// one flop chain per payload bit, asserts the moment the bit or the chip
// reset goes low, releases after CLKRST_SYNC_STAGES rising edges
// works on any packed payload, bit order kept as given

`timescale 1ns/1ps

`include "clkrst_consts.svh"

module rst_sync_bank #(
  parameter type payload_t = logic  // packed payload, struct or vector
) (
  input  logic     iCLK_SERDES_RXREC,
  input  logic     arst_n,     // chip level async reset
  input  payload_t async_in,   // active low, any timing
  output payload_t sync_out    // active low, release on clock
);

  localparam int WIDTH = $bits(payload_t);

  logic [WIDTH-1:0] in_bits;   // flat view of the payload
  wire  [WIDTH-1:0] out_bits;  // one driver per bit from g_bit

  assign in_bits  = async_in;
  assign sync_out = payload_t'(out_bits);

  ////////////////////////////////////////////////////////////
  // per bit chains
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < WIDTH; b++)
  begin : g_bit
    logic                           clr_n;  // bit low or chip reset
    logic [`CLKRST_SYNC_STAGES-1:0] chain;

    assign clr_n = in_bits[b] & arst_n;

    // async assert, ones walk in on release
    always_ff @(posedge iCLK_SERDES_RXREC or negedge clr_n)
    begin
      if (!clr_n)
        chain <= '0;
      else
        chain <= {chain[`CLKRST_SYNC_STAGES-2:0], 1'b1};
    end

    assign out_bits[b] = chain[`CLKRST_SYNC_STAGES-1];  // last stage out
  end

endmodule

//--- flist.f
+incdir+design
design/clkrst_pkg.sv
design/rst_request_gen.sv
design/rst_sync_bank.sv
design/rst_status_track.sv
design/clkrst_top.sv
bench/clkrst_props.sv
bench/clkrst_tb.sv
